/* verilog/ofdm_consts.svh */
`ifndef OFDM_CONSTS_SVH
`define OFDM_CONSTS_SVH

// transform size
`define OFDM_NFFT        4
`define OFDM_FFT_LEN     16

// sample word and component widths
`define OFDM_SAMPLE_W    32
`define OFDM_COMP_W      16

// cyclic prefix length field and its largest legal value
`define OFDM_CP_W        3
`define OFDM_CP_MAX      5

// twiddle fraction bits, unity is 16384
`define OFDM_TW_FRAC     14

// windows over centred output positions
`define OFDM_BWP_LEN     12
`define OFDM_SC_START    2
`define OFDM_PBCH_START  3
`define OFDM_PBCH_LEN    10
`define OFDM_SSS_START   4
`define OFDM_SSS_LEN     7

`define OFDM_META_DEPTH  4

`endif

/* verilog/ofdm_pkg.sv */
`default_nettype none

`include "ofdm_consts.svh"

package ofdm_pkg;

    // metadata field widths, user word is {sfn, subframe, symbol}
    localparam int SFN_W      = 10;
    localparam int SUBFRAME_W = 5;
    localparam int SYMBOL_W   = 4;
    localparam int META_W     = SFN_W + SUBFRAME_W + SYMBOL_W;

    // input user word adds the cp length below the metadata
    localparam int IN_USER_W  = META_W + `OFDM_CP_W;
    // output user word adds the pbch-symbol bit below the metadata
    localparam int OUT_USER_W = META_W + 1;

    // imaginary part sits in the upper half of the word
    typedef struct packed {
        logic signed [`OFDM_COMP_W-1:0] im;
        logic signed [`OFDM_COMP_W-1:0] re;
    } cplx_t;

    typedef union packed {
        logic [`OFDM_SAMPLE_W-1:0] raw;
        cplx_t                     cplx;
    } sample_u;

endpackage

`default_nettype wire

/* verilog/cp_remover.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ofdm_consts.svh"

module cp_remover
    import ofdm_pkg::*;
(
    input  wire                  clk_i,
    input  wire                  reset_ni,
    input  wire sample_u         in_data_i,
    input  wire [IN_USER_W-1:0]  in_user_i,
    input  wire                  in_last_i,
    input  wire                  in_valid_i,
    input  wire                  ssb_start_i,
    output sample_u              sym_data_o,
    output logic                 sym_valid_o,
    output logic [META_W-1:0]    meta_o,
    output logic                 meta_push_o
);

    localparam int CP_W    = `OFDM_CP_W;
    localparam int NFFT    = `OFDM_NFFT;
    localparam int FFT_LEN = `OFDM_FFT_LEN;

    localparam logic [1:0] S_SKIP_CP  = 2'd0;
    localparam logic [1:0] S_BODY     = 2'd1;
    localparam logic [1:0] S_SKIP_END = 2'd2;

    logic [1:0]      state;
    logic [CP_W-1:0] cp_len_q;
    logic [CP_W-1:0] cp_cnt;
    logic [NFFT-1:0] body_cnt;
    logic            first;
    logic            take;

    // once cp_cnt has reached the cp length the current sample opens the body
    always_comb begin
        first = (state == S_SKIP_CP) && in_valid_i && !ssb_start_i && (cp_cnt == cp_len_q);
        take  = first || ((state == S_BODY) && in_valid_i);
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state       <= S_SKIP_CP;
            cp_len_q    <= CP_W'(`OFDM_CP_MAX);
            cp_cnt      <= '0;
            body_cnt    <= '0;
            sym_valid_o <= 1'b0;
            meta_push_o <= 1'b0;
        end else begin
            sym_valid_o <= take;
            meta_push_o <= first;

            // cp length travels with every sample
            if (in_valid_i) begin
                cp_len_q <= in_user_i[CP_W-1:0];
            end

            case (state)
                S_SKIP_CP: begin
                    if (ssb_start_i) begin
                        // restart the cp count, a sample on the pulse is cp sample one
                        cp_cnt <= CP_W'(in_valid_i);
                    end else if (first) begin
                        state    <= S_BODY;
                        body_cnt <= NFFT'(1);
                    end else if (in_valid_i) begin
                        cp_cnt <= cp_cnt + 1'b1;
                    end
                end
                S_BODY: begin
                    if (in_valid_i) begin
                        body_cnt <= body_cnt + 1'b1;
                        if (body_cnt == NFFT'(FFT_LEN - 1)) begin
                            cp_cnt <= '0;
                            state  <= in_last_i ? S_SKIP_CP : S_SKIP_END;
                        end
                    end
                end
                S_SKIP_END: begin
                    if (in_valid_i && in_last_i) begin
                        state  <= S_SKIP_CP;
                        cp_cnt <= '0;
                    end else if (ssb_start_i) begin
                        // early ssb, jump forward into the next cp
                        state  <= S_SKIP_CP;
                        cp_cnt <= CP_W'(in_valid_i);
                    end
                end
                default: begin
                    state  <= S_SKIP_CP;
                    cp_cnt <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            sym_data_o <= in_data_i;
        end
        if (first) begin
            meta_o <= in_user_i[IN_USER_W-1 -: META_W];
        end
    end

endmodule

`default_nettype wire

/* verilog/meta_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ofdm_consts.svh"

module meta_fifo
    import ofdm_pkg::*;
(
    input  wire                clk_i,
    input  wire                reset_ni,
    input  wire                push_i,
    input  wire [META_W-1:0]   data_i,
    input  wire                pop_i,
    output logic [META_W-1:0]  data_o,
    output logic               not_empty_o
);

    localparam int DEPTH = `OFDM_META_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    logic [META_W-1:0] mem [DEPTH];
    // extra msb tells full from empty
    logic [AW:0]       wr_ptr;
    logic [AW:0]       rd_ptr;
    logic              full;

    always_comb begin
        full        = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
        not_empty_o = (wr_ptr != rd_ptr);
        data_o      = mem[rd_ptr[AW-1:0]];
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i && not_empty_o) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i && !full) begin
            mem[wr_ptr[AW-1:0]] <= data_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/dft_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ofdm_consts.svh"

module dft_engine
    import ofdm_pkg::*;
(
    input  wire                    clk_i,
    input  wire                    reset_ni,
    input  wire sample_u           sym_data_i,
    input  wire                    sym_valid_i,
    input  wire                    sym_first_i,
    output sample_u                bin_data_o,
    output logic                   bin_valid_o,
    output logic [`OFDM_NFFT-1:0]  bin_pos_o
);

    localparam int NFFT    = `OFDM_NFFT;
    localparam int FFT_LEN = `OFDM_FFT_LEN;
    localparam int COMP_W  = `OFDM_COMP_W;
    localparam int ACC_W   = COMP_W + NFFT + 2;
    localparam int PROD_W  = 2 * COMP_W + 1;
    localparam logic [NFFT-1:0] HALF = NFFT'(FFT_LEN / 2);

    // cos(2*pi*m/16) scaled by 2^14
    function automatic logic signed [COMP_W-1:0] cos_tw(input logic [NFFT-1:0] m);
        case (m)
            4'd0:    cos_tw = 16'sd16384;
            4'd1:    cos_tw = 16'sd15137;
            4'd2:    cos_tw = 16'sd11585;
            4'd3:    cos_tw = 16'sd6270;
            4'd4:    cos_tw = 16'sd0;
            4'd5:    cos_tw = -16'sd6270;
            4'd6:    cos_tw = -16'sd11585;
            4'd7:    cos_tw = -16'sd15137;
            4'd8:    cos_tw = -16'sd16384;
            4'd9:    cos_tw = -16'sd15137;
            4'd10:   cos_tw = -16'sd11585;
            4'd11:   cos_tw = -16'sd6270;
            4'd12:   cos_tw = 16'sd0;
            4'd13:   cos_tw = 16'sd6270;
            4'd14:   cos_tw = 16'sd11585;
            default: cos_tw = 16'sd15137;
        endcase
    endfunction

    logic [NFFT-1:0]          idx;
    logic [NFFT-1:0]          n_eff;
    logic signed [ACC_W-1:0]  acc_re  [FFT_LEN];
    logic signed [ACC_W-1:0]  acc_im  [FFT_LEN];
    logic signed [ACC_W-1:0]  prod_re [FFT_LEN];
    logic signed [ACC_W-1:0]  prod_im [FFT_LEN];
    logic signed [COMP_W-1:0] bank_re [FFT_LEN];
    logic signed [COMP_W-1:0] bank_im [FFT_LEN];
    logic                     done_q;
    logic                     streaming;
    logic [NFFT-1:0]          out_cnt;

    // x[n] * W^(k*n) for every bin k, W = exp(-j*2*pi/16)
    always_comb begin : twiddle_mult
        logic [NFFT-1:0]          m;
        logic signed [COMP_W-1:0] wr;
        logic signed [COMP_W-1:0] wi;
        logic signed [PROD_W-1:0] pr;
        logic signed [PROD_W-1:0] pim;
        n_eff = sym_first_i ? '0 : idx;
        for (int k = 0; k < FFT_LEN; k++) begin
            m  = NFFT'(k * n_eff);
            wr = cos_tw(m);
            // -sin(theta) is -cos(theta - pi/2)
            wi = -cos_tw(m + NFFT'(12));
            pr  = sym_data_i.cplx.re * wr - sym_data_i.cplx.im * wi;
            pim = sym_data_i.cplx.re * wi + sym_data_i.cplx.im * wr;
            prod_re[k] = ACC_W'(pr >>> `OFDM_TW_FRAC);
            prod_im[k] = ACC_W'(pim >>> `OFDM_TW_FRAC);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            idx         <= '0;
            done_q      <= 1'b0;
            streaming   <= 1'b0;
            out_cnt     <= '0;
            bin_valid_o <= 1'b0;
            bin_pos_o   <= '0;
        end else begin
            if (sym_valid_i) begin
                idx <= n_eff + 1'b1;
            end
            done_q <= sym_valid_i && (n_eff == NFFT'(FFT_LEN - 1));

            // a new bank restarts the read-out even if the old one is on its last bin
            if (done_q) begin
                streaming <= 1'b1;
                out_cnt   <= '0;
            end else if (streaming) begin
                out_cnt <= out_cnt + 1'b1;
                if (out_cnt == NFFT'(FFT_LEN - 1)) begin
                    streaming <= 1'b0;
                end
            end

            bin_valid_o <= streaming;
            if (streaming) begin
                bin_pos_o <= out_cnt;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int k = 0; k < FFT_LEN; k++) begin
            if (done_q) begin
                bank_re[k] <= COMP_W'(acc_re[k] >>> NFFT);
                bank_im[k] <= COMP_W'(acc_im[k] >>> NFFT);
            end
            if (sym_valid_i) begin
                acc_re[k] <= (sym_first_i ? '0 : acc_re[k]) + prod_re[k];
                acc_im[k] <= (sym_first_i ? '0 : acc_im[k]) + prod_im[k];
            end else if (done_q) begin
                acc_re[k] <= '0;
                acc_im[k] <= '0;
            end
        end
        // centred order, DC lands on position 8
        bin_data_o.cplx.re <= bank_re[out_cnt + HALF];
        bin_data_o.cplx.im <= bank_im[out_cnt + HALF];
    end

endmodule

`default_nettype wire

/* verilog/subcarrier_framer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ofdm_consts.svh"

module subcarrier_framer
    import ofdm_pkg::*;
(
    input  wire                    clk_i,
    input  wire                    reset_ni,
    input  wire sample_u           bin_data_i,
    input  wire                    bin_valid_i,
    input  wire [`OFDM_NFFT-1:0]   bin_pos_i,
    input  wire [META_W-1:0]       meta_i,
    input  wire                    meta_valid_i,
    output logic                   meta_pop_o,
    output sample_u                out_data_o,
    output logic [OUT_USER_W-1:0]  out_user_o,
    output logic                   out_last_o,
    output logic                   out_valid_o,
    output logic                   pbch_valid_o,
    output logic                   sss_valid_o
);

    localparam int SC_LAST   = `OFDM_SC_START + `OFDM_BWP_LEN - 1;
    localparam int PBCH_LAST = `OFDM_PBCH_START + `OFDM_PBCH_LEN - 1;
    localparam int SSS_LAST  = `OFDM_SSS_START + `OFDM_SSS_LEN - 1;

    logic [SUBFRAME_W-1:0] head_subframe;
    logic [SYMBOL_W-1:0]   head_symbol;
    logic                  pbch_sym;
    logic                  sss_sym;
    logic                  in_bwp;
    logic                  in_pbch;
    logic                  in_sss;

    always_comb begin
        head_symbol   = meta_i[SYMBOL_W-1:0];
        head_subframe = meta_i[SYMBOL_W +: SUBFRAME_W];
        // pbch and sss only live in symbols 3 and 4 of subframe 0
        pbch_sym = meta_valid_i && (head_subframe == '0) && (head_symbol == SYMBOL_W'(3));
        sss_sym  = meta_valid_i && (head_subframe == '0) && (head_symbol == SYMBOL_W'(4));
        in_bwp   = (bin_pos_i >= `OFDM_SC_START) && (bin_pos_i <= SC_LAST);
        in_pbch  = (bin_pos_i >= `OFDM_PBCH_START) && (bin_pos_i <= PBCH_LAST);
        in_sss   = (bin_pos_i >= `OFDM_SSS_START) && (bin_pos_i <= SSS_LAST);
        // release the head once the whole symbol has streamed past
        meta_pop_o = bin_valid_i && (bin_pos_i == `OFDM_NFFT'(`OFDM_FFT_LEN - 1));
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            out_valid_o  <= 1'b0;
            out_last_o   <= 1'b0;
            pbch_valid_o <= 1'b0;
            sss_valid_o  <= 1'b0;
        end else begin
            out_valid_o  <= bin_valid_i && in_bwp;
            out_last_o   <= bin_valid_i && (bin_pos_i == SC_LAST);
            pbch_valid_o <= bin_valid_i && pbch_sym && in_pbch;
            sss_valid_o  <= bin_valid_i && sss_sym && in_sss;
        end
    end

    always_ff @(posedge clk_i) begin
        out_data_o <= bin_data_i;
        out_user_o <= {meta_i, pbch_sym};
    end

endmodule

`default_nettype wire

/* verilog/ofdm_demod.sv */
`timescale 1ns/1ps
`default_nettype none

module ofdm_demod
    import ofdm_pkg::*;
(
    input  wire                    clk_i,
    input  wire                    reset_ni,
    input  wire sample_u           in_data_i,
    input  wire [IN_USER_W-1:0]    in_user_i,
    input  wire                    in_last_i,
    input  wire                    in_valid_i,
    input  wire                    ssb_start_i,
    output sample_u                out_data_o,
    output logic [OUT_USER_W-1:0]  out_user_o,
    output logic                   out_last_o,
    output logic                   out_valid_o,
    output logic                   pbch_valid_o,
    output logic                   sss_valid_o
);

    sample_u           sym_data;
    logic              sym_valid;
    logic [META_W-1:0] meta_data;
    // the push marks the first body sample, so it doubles as sym_first
    logic              meta_push;
    logic [META_W-1:0] meta_head;
    logic              meta_not_empty;
    logic              meta_pop;
    sample_u           bin_data;
    logic              bin_valid;
    logic [3:0]        bin_pos;

    cp_remover u_cp_remover (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_data_i   (in_data_i),
        .in_user_i   (in_user_i),
        .in_last_i   (in_last_i),
        .in_valid_i  (in_valid_i),
        .ssb_start_i (ssb_start_i),
        .sym_data_o  (sym_data),
        .sym_valid_o (sym_valid),
        .meta_o      (meta_data),
        .meta_push_o (meta_push)
    );

    meta_fifo u_meta_fifo (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .push_i      (meta_push),
        .data_i      (meta_data),
        .pop_i       (meta_pop),
        .data_o      (meta_head),
        .not_empty_o (meta_not_empty)
    );

    dft_engine u_dft_engine (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .sym_data_i  (sym_data),
        .sym_valid_i (sym_valid),
        .sym_first_i (meta_push),
        .bin_data_o  (bin_data),
        .bin_valid_o (bin_valid),
        .bin_pos_o   (bin_pos)
    );

    subcarrier_framer u_subcarrier_framer (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .bin_data_i   (bin_data),
        .bin_valid_i  (bin_valid),
        .bin_pos_i    (bin_pos),
        .meta_i       (meta_head),
        .meta_valid_i (meta_not_empty),
        .meta_pop_o   (meta_pop),
        .out_data_o   (out_data_o),
        .out_user_o   (out_user_o),
        .out_last_o   (out_last_o),
        .out_valid_o  (out_valid_o),
        .pbch_valid_o (pbch_valid_o),
        .sss_valid_o  (sss_valid_o)
    );

endmodule

`default_nettype wire

/* testbench/ofdm_demod_sva.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ofdm_consts.svh"

module ofdm_demod_sva (
    input wire clk_i,
    input wire reset_ni,
    input wire out_valid_i,
    input wire out_last_i,
    input wire pbch_valid_i,
    input wire sss_valid_i,
    input wire meta_push_i,
    input wire meta_pop_i,
    input wire meta_not_empty_i
);

    localparam int DEPTH = `OFDM_META_DEPTH;

    // metadata fifo occupancy, followed from its push and pop strobes
    logic [3:0] level;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            level <= '0;
        end else begin
            level <= level + 4'(meta_push_i && (level < DEPTH))
                           - 4'(meta_pop_i && meta_not_empty_i);
        end
    end

    last_needs_valid: assert property (@(posedge clk_i) disable iff (!reset_ni)
        out_last_i |-> out_valid_i)
        else $error("out_last_o high without out_valid_o");

    pbch_needs_valid: assert property (@(posedge clk_i) disable iff (!reset_ni)
        pbch_valid_i |-> out_valid_i)
        else $error("pbch_valid_o high without out_valid_o");

    sss_needs_valid: assert property (@(posedge clk_i) disable iff (!reset_ni)
        sss_valid_i |-> out_valid_i)
        else $error("sss_valid_o high without out_valid_o");

    no_push_when_full: assert property (@(posedge clk_i) disable iff (!reset_ni)
        meta_push_i |-> (level < DEPTH))
        else $error("metadata pushed into a full FIFO");

endmodule

bind ofdm_demod ofdm_demod_sva u_ofdm_demod_sva (
    .clk_i            (clk_i),
    .reset_ni         (reset_ni),
    .out_valid_i      (out_valid_o),
    .out_last_i       (out_last_o),
    .pbch_valid_i     (pbch_valid_o),
    .sss_valid_i      (sss_valid_o),
    .meta_push_i      (meta_push),
    .meta_pop_i       (meta_pop),
    .meta_not_empty_i (meta_not_empty)
);

`default_nettype wire

/* testbench/tb_ofdm_demod.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ofdm_consts.svh"

module tb_ofdm_demod
    import ofdm_pkg::*;
();

    localparam int CLK_PERIOD     = 20;
    localparam int NUM_BINS       = `OFDM_BWP_LEN;
    // 20 symbols of at most 40 cycles each, plus reset and settling
    localparam int TIMEOUT_CYCLES = 20 * 40 + 200;
    localparam logic signed [15:0] IMPULSE_AMP = 16'sd1600;

    logic                  clk;
    logic                  reset_n;
    sample_u               in_data;
    logic [IN_USER_W-1:0]  in_user;
    logic                  in_last;
    logic                  in_valid;
    logic                  ssb_start;
    sample_u               out_data;
    logic [OUT_USER_W-1:0] out_user;
    logic                  out_last;
    logic                  out_valid;
    logic                  pbch_valid;
    logic                  sss_valid;

    logic [31:0]           data_q[$];
    logic [OUT_USER_W-1:0] user_q[$];
    // {last, pbch, sss} per output beat
    logic [2:0]            flag_q[$];
    logic [META_W-1:0]     exp_meta_q[$];
    int                    check_count;
    int                    error_count;
    int                    cycle_count;

    ofdm_demod u_ofdm_demod (
        .clk_i        (clk),
        .reset_ni     (reset_n),
        .in_data_i    (in_data),
        .in_user_i    (in_user),
        .in_last_i    (in_last),
        .in_valid_i   (in_valid),
        .ssb_start_i  (ssb_start),
        .out_data_o   (out_data),
        .out_user_o   (out_user),
        .out_last_o   (out_last),
        .out_valid_o  (out_valid),
        .pbch_valid_o (pbch_valid),
        .sss_valid_o  (sss_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        error_count = error_count + 1;
        $display("timeout: the DUT did not deliver all outputs within %0d cycles", TIMEOUT_CYCLES);
        print_counts();
        $display("Regression failed");
        $finish;
    end

    task automatic print_counts();
        $display("checks run: %0d, errors: %0d", check_count, error_count);
    endtask

    task automatic check_value(input string test_name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        check_count = check_count + 1;
        if (expected !== actual) begin
            error_count = error_count + 1;
            $display("CHECK FAILED [%s] %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    // bin k of the impulse is 100 * (-j)^k
    // position p holds bin (p+8) mod 16
    function automatic logic [31:0] impulse_bin(input int pos);
        int                 k;
        logic signed [15:0] re;
        logic signed [15:0] im;
        k  = (pos + 8) % 16;
        re = 16'sd0;
        im = 16'sd0;
        case (k % 4)
            0:       re = 16'sd100;
            1:       im = -16'sd100;
            2:       re = -16'sd100;
            default: im = 16'sd100;
        endcase
        return {im, re};
    endfunction

    function automatic logic [META_W-1:0] make_meta(input int sfn, input int subframe,
                                                    input int symbol);
        return {SFN_W'(sfn), SUBFRAME_W'(subframe), SYMBOL_W'(symbol)};
    endfunction

    task automatic drive_sample(input logic [31:0] data, input logic [IN_USER_W-1:0] user,
                                input logic last, input logic ssb);
        @(posedge clk);
        #2;
        in_data.raw = data;
        in_user     = user;
        in_last     = last;
        in_valid    = 1'b1;
        ssb_start   = ssb;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #2;
        in_data.raw = '0;
        in_last     = 1'b0;
        in_valid    = 1'b0;
        ssb_start   = 1'b0;
    endtask

    // cp filler, 16 body samples with the impulse at n = 4, optional trailing filler
    task automatic send_symbol(input int cp_len, input logic [META_W-1:0] meta,
                               input int trail, input logic ssb_first);
        logic [IN_USER_W-1:0] user;
        logic [31:0]          body;
        user = {meta, `OFDM_CP_W'(cp_len)};
        for (int i = 0; i < cp_len; i++) begin
            drive_sample($urandom, user, 1'b0, ssb_first && (i == 0));
        end
        for (int i = 0; i < `OFDM_FFT_LEN; i++) begin
            body = (i == 4) ? {16'd0, IMPULSE_AMP} : 32'd0;
            drive_sample(body, user, (trail == 0) && (i == `OFDM_FFT_LEN - 1), 1'b0);
        end
        for (int i = 0; i < trail; i++) begin
            drive_sample($urandom, user, i == trail - 1, 1'b0);
        end
        exp_meta_q.push_back(meta);
    endtask

    task automatic collect_outputs();
        forever begin
            @(negedge clk);
            if (out_valid) begin
                data_q.push_back(out_data.raw);
                user_q.push_back(out_user);
                flag_q.push_back({out_last, pbch_valid, sss_valid});
            end
        end
    endtask

    task automatic verify_symbols(input string test_name);
        int                n_sym;
        int                idx;
        int                pos;
        logic [META_W-1:0] meta;
        logic              pbch_sym;
        logic              sss_sym;
        logic [2:0]        exp_flags;
        n_sym = exp_meta_q.size();
        while (data_q.size() < n_sym * NUM_BINS) begin
            @(negedge clk);
        end
        // extra beats would show up here
        repeat (10) @(negedge clk);
        check_value(test_name, "output count", n_sym * NUM_BINS, data_q.size());
        for (int s = 0; s < n_sym; s++) begin
            meta     = exp_meta_q[s];
            pbch_sym = (meta[SYMBOL_W +: SUBFRAME_W] == 0) && (meta[SYMBOL_W-1:0] == 3);
            sss_sym  = (meta[SYMBOL_W +: SUBFRAME_W] == 0) && (meta[SYMBOL_W-1:0] == 4);
            for (int i = 0; i < NUM_BINS; i++) begin
                idx = s * NUM_BINS + i;
                pos = `OFDM_SC_START + i;
                exp_flags[2] = (i == NUM_BINS - 1);
                exp_flags[1] = pbch_sym && (pos >= 3) && (pos <= 12);
                exp_flags[0] = sss_sym && (pos >= 4) && (pos <= 10);
                check_value(test_name, $sformatf("data pos %0d", pos), impulse_bin(pos),
                            data_q[idx]);
                check_value(test_name, $sformatf("user pos %0d", pos), {meta, pbch_sym},
                            user_q[idx]);
                check_value(test_name, $sformatf("last/pbch/sss pos %0d", pos), exp_flags,
                            flag_q[idx]);
            end
        end
        data_q.delete();
        user_q.delete();
        flag_q.delete();
        exp_meta_q.delete();
    endtask

    task automatic idle_after_reset();
        repeat (20) begin
            @(negedge clk);
            check_value("reset_idle", "valid/last/pbch/sss", 4'b0000,
                        {out_valid, out_last, pbch_valid, sss_valid});
        end
    endtask

    task automatic single_impulse();
        send_symbol(4, make_meta(17, 2, 5), 0, 1'b0);
        drive_idle();
        verify_symbols("impulse");
    endtask

    task automatic back_to_back_symbols();
        send_symbol(5, make_meta(18, 3, 0), 0, 1'b0);
        send_symbol(3, make_meta(18, 3, 1), 0, 1'b0);
        send_symbol(4, make_meta(18, 3, 2), 0, 1'b0);
        drive_idle();
        verify_symbols("back_to_back");
    endtask

    task automatic pbch_sss_flags();
        send_symbol(4, make_meta(20, 0, 3), 0, 1'b0);
        send_symbol(4, make_meta(20, 0, 4), 0, 1'b0);
        send_symbol(4, make_meta(20, 1, 3), 0, 1'b0);
        drive_idle();
        verify_symbols("flags");
    endtask

    task automatic trailing_samples();
        send_symbol(4, make_meta(21, 5, 6), 3, 1'b0);
        send_symbol(5, make_meta(21, 5, 7), 0, 1'b0);
        drive_idle();
        verify_symbols("trailing");
    endtask

    task automatic ssb_realign();
        logic [META_W-1:0] meta;
        meta = make_meta(22, 7, 8);
        // junk ahead of the true symbol start
        drive_sample($urandom, {meta, `OFDM_CP_W'(4)}, 1'b0, 1'b0);
        drive_sample($urandom, {meta, `OFDM_CP_W'(4)}, 1'b0, 1'b0);
        send_symbol(4, meta, 0, 1'b1);
        drive_idle();
        verify_symbols("ssb_realign");
    endtask

    initial begin
        in_data.raw = '0;
        in_user     = '0;
        in_last     = 1'b0;
        in_valid    = 1'b0;
        ssb_start   = 1'b0;
        reset_n     = 1'b0;
        check_count = 0;
        error_count = 0;
        // seed the generator once for the whole run
        void'($urandom(42));
        fork
            collect_outputs();
        join_none
        repeat (10) @(posedge clk);
        #2;
        reset_n = 1'b1;

        idle_after_reset();
        single_impulse();
        back_to_back_symbols();
        pbch_sss_flags();
        trailing_samples();
        ssb_realign();

        print_counts();
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+verilog
verilog/ofdm_pkg.sv
verilog/cp_remover.sv
verilog/meta_fifo.sv
verilog/dft_engine.sv
verilog/subcarrier_framer.sv
verilog/ofdm_demod.sv
testbench/ofdm_demod_sva.sv
testbench/tb_ofdm_demod.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the ofdm demodulator regression with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_ofdm_demod -Mdir obj_dir -o tb_ofdm_demod \
    || { echo "verilator build failed"; exit 1; }

# an abnormal exit of the simulation counts as a failure in the log
./obj_dir/tb_ofdm_demod > sim.log 2>&1 || echo "Regression failed" >> sim.log
cat sim.log

grep -q "Regression failed" sim.log && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation PASSED"; exit 0; }
